// ==== bench/oob_checker.sv ====
// testbench monitor, samples the DUT ports every cycle and grades each test when it ends
`timescale 1ns/100ps
`default_nettype none
`include "sata_oob_config.svh"

module oob_checker
    import sata_prim_pkg::*;
    import oob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       platform_ready,
    input  logic       end_test,
    input  int         test_num,
    input  logic       init_f,
    input  logic       wake_f,
    input  logic       align_f,
    input  logic       sync_f,
    input  logic       exp_linkup,
    input  logic       linkup,
    input  logic       tx_comm_reset,
    input  logic       tx_comm_wake,
    input  logic       tx_isk,
    input  logic       tx_set_elec_idle,
    input  dword_t     tx_dout,
    input  oob_state_e oob_state,
    output int         error_count,
    output int         failed_tests,
    output int         tests_done
);

    int   reset_run;
    int   reset_bursts;
    int   wake_run;
    int   wake_bursts;
    int   linkup_rises;
    int   dial_cycles;
    int   align_cycles;
    int   gap_cycles;
    int   test_errors;
    logic linkup_q;

    initial begin
        error_count  = 0;
        failed_tests = 0;
        tests_done   = 0;
    end

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // shortest quiet time before the host may retry
    // the first wait the device leaves unanswered sets it
    function automatic int min_restart_gap(input logic i, input logic w, input logic a,
                                           input logic s);
        if (!i) begin
            min_restart_gap = `INIT_TIMEOUT;
        end else if (!w) begin
            min_restart_gap = `WAKE_TIMEOUT;
        end else if (!a) begin
            min_restart_gap = `ALIGN_TIMEOUT;
        end else if (!s) begin
            min_restart_gap = `SYNC_TIMEOUT;
        end else begin
            // linked run restarts on the device COMINIT, no wait involved
            min_restart_gap = 0;
        end
    endfunction

    task automatic grade_test();
        int min_gap;
        min_gap = min_restart_gap(init_f, wake_f, align_f, sync_f);
        // test ends as the retry burst starts, so one burst is complete
        expect_value("tx_comm_reset bursts", 32'(reset_bursts), 1);
        expect_value("tx_comm_reset", 32'(tx_comm_reset), 1);
        expect_value("oob_state", 32'(oob_state), 32'(SEND_RESET));
        expect_value("tx_comm_wake bursts", 32'(wake_bursts), 32'(init_f));
        expect_value("dialtone seen", 32'(dial_cycles > 0), 32'(init_f && wake_f));
        expect_value("ALIGN sent", 32'(align_cycles > 0), 32'(init_f && wake_f && align_f));
        expect_value("linkup rises", 32'(linkup_rises), 32'(exp_linkup));
        expect_value("linkup", 32'(linkup), 0);
        if (gap_cycles < min_gap) begin
            $display("FAIL t=%0t test %0d COMRESET retry after %0d cycles, timeout is %0d",
                     $time, test_num, gap_cycles, min_gap);
            error_count++;
            test_errors++;
        end
        tests_done++;
        if (test_errors == 0) begin
            $display("test %0d: ok", test_num);
        end else begin
            failed_tests++;
            $display("test %0d: %0d errors", test_num, test_errors);
        end
    endtask

    // DUT outputs change on this edge by NBA, so the old values are read here
    always @(posedge clk) begin
        if (rst) begin
            reset_run    = 0;
            reset_bursts = 0;
            wake_run     = 0;
            wake_bursts  = 0;
            linkup_rises = 0;
            dial_cycles  = 0;
            align_cycles = 0;
            gap_cycles   = 0;
            test_errors  = 0;
            linkup_q     = 1'b0;
        end else begin
            // host must sit quiet with the line idle until the platform is ready
            if (!platform_ready) begin
                expect_value("tx_set_elec_idle", 32'(tx_set_elec_idle), 1);
                expect_value("tx_comm_reset", 32'(tx_comm_reset), 0);
                expect_value("tx_comm_wake", 32'(tx_comm_wake), 0);
                expect_value("linkup", 32'(linkup), 0);
                expect_value("tx_dout", tx_dout, 0);
                expect_value("oob_state", 32'(oob_state), 32'(IDLE));
            end
            // link is only up in the final state
            if (linkup) begin
                expect_value("oob_state", 32'(oob_state), 32'(READY));
            end
            // COMRESET burst length, graded on the falling edge
            if (tx_comm_reset) begin
                reset_run++;
            end else if (reset_run > 0) begin
                expect_value("tx_comm_reset cycles", 32'(reset_run), `COMRESET_CYCLES + 1);
                reset_bursts++;
                reset_run = 0;
            end
            if ((reset_bursts > 0) && !tx_comm_reset) begin
                gap_cycles++;
            end
            // COMWAKE burst length
            if (tx_comm_wake) begin
                wake_run++;
            end else if (wake_run > 0) begin
                expect_value("tx_comm_wake cycles", 32'(wake_run), `COMWAKE_CYCLES + 1);
                wake_bursts++;
                wake_run = 0;
            end
            // off idle the host sends dialtone or ALIGN and nothing else
            if (!tx_set_elec_idle) begin
                if (tx_isk) begin
                    expect_value("tx_dout", tx_dout, `PRIM_ALIGN);
                    align_cycles++;
                end else begin
                    expect_value("tx_dout", tx_dout, `DIALTONE);
                    dial_cycles++;
                end
            end else begin
                expect_value("tx_isk", 32'(tx_isk), 0);
            end
            if (linkup && !linkup_q) begin
                linkup_rises++;
            end
            linkup_q = linkup;
            if (end_test) begin
                grade_test();
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/oob_input.txt ====
// one record per line, all fields hex
// test init_resp wake_resp align_resp sync_resp expected_linkup
1 0 0 0 0 0
2 1 0 0 0 0
3 1 1 0 0 0
4 1 1 1 0 0
5 1 1 1 1 1
// a second full bring-up after a fresh reset
6 1 1 1 1 1

// ==== bench/tb_sata_oob.sv ====
// testbench top, reads device behaviors from the data file and drives the DUT as a SATA device
`timescale 1ns/100ps
`default_nettype none
`include "sata_oob_config.svh"

module tb_sata_oob
    import sata_prim_pkg::*;
    import oob_pkg::*;
;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_TESTS   = 6;
    localparam int FIELDS      = 6;
    // device answers a burst for this many cycles
    localparam int RESP_CYCLES = 10;
    // linked cycles before the device sends its COMINIT
    localparam int LINKED_HOLD = 8;
    // every wait and both bursts, plus reset and idle cycles, for each test, doubled
    localparam int WATCHDOG_CYCLES = (`INIT_TIMEOUT + `WAKE_TIMEOUT + `ALIGN_TIMEOUT
        + `SYNC_TIMEOUT + `COMRESET_CYCLES + `COMWAKE_CYCLES + 16) * NUM_TESTS * 2;

    logic        clk;
    logic        rst;
    logic        platform_ready;
    logic        end_test;
    dword_t      rx_din             = '0;
    charisk_t    rx_isk             = '0;
    logic        rx_byte_is_aligned = 1'b0;
    logic        comm_init_detect   = 1'b0;
    logic        comm_wake_detect   = 1'b0;
    logic        linkup;
    logic        tx_comm_reset;
    logic        tx_comm_wake;
    logic        tx_isk;
    logic        tx_set_elec_idle;
    dword_t      tx_dout;
    oob_state_e  oob_state;
    int          cur_test           = 0;
    logic        cur_init           = 1'b0;
    logic        cur_wake           = 1'b0;
    logic        cur_align          = 1'b0;
    logic        cur_sync           = 1'b0;
    logic        cur_exp            = 1'b0;
    logic [31:0] vectors [0:NUM_TESTS*FIELDS-1];
    int          error_count;
    int          failed_tests;
    int          tests_done;
    int          load_errors;
    int          rises;
    logic        burst_q;
    // device model state
    int          init_cnt;
    int          wake_cnt;
    int          linked_cycles;
    logic        reset_q;
    logic        wake_q;
    logic        host_aligned;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    sata_oob_top dut (
        .clk                (clk),
        .rst                (rst),
        .platform_ready     (platform_ready),
        .rx_din             (rx_din),
        .rx_isk             (rx_isk),
        .rx_byte_is_aligned (rx_byte_is_aligned),
        .comm_init_detect   (comm_init_detect),
        .comm_wake_detect   (comm_wake_detect),
        .linkup             (linkup),
        .tx_comm_reset      (tx_comm_reset),
        .tx_comm_wake       (tx_comm_wake),
        .tx_isk             (tx_isk),
        .tx_set_elec_idle   (tx_set_elec_idle),
        .tx_dout            (tx_dout),
        .oob_state          (oob_state)
    );

    oob_checker u_checker (
        .clk (clk), .rst (rst), .platform_ready (platform_ready), .end_test (end_test),
        .test_num (cur_test), .init_f (cur_init), .wake_f (cur_wake), .align_f (cur_align),
        .sync_f (cur_sync), .exp_linkup (cur_exp), .linkup (linkup),
        .tx_comm_reset (tx_comm_reset), .tx_comm_wake (tx_comm_wake), .tx_isk (tx_isk),
        .tx_set_elec_idle (tx_set_elec_idle), .tx_dout (tx_dout), .oob_state (oob_state),
        .error_count (error_count), .failed_tests (failed_tests), .tests_done (tests_done)
    );

    // device model, answers bursts with detect levels and the rx stream with primitives
    always @(negedge clk) begin
        if (rst) begin
            init_cnt      = 0;
            wake_cnt      = 0;
            linked_cycles = 0;
            reset_q       = 1'b0;
            wake_q        = 1'b0;
            host_aligned  = 1'b0;
            comm_init_detect = 1'b0;
            comm_wake_detect = 1'b0;
        end else begin
            // answer after the host burst has ended
            if (reset_q && !tx_comm_reset && cur_init) begin
                init_cnt = RESP_CYCLES;
            end
            if (wake_q && !tx_comm_wake && cur_wake) begin
                wake_cnt = RESP_CYCLES;
            end
            reset_q = tx_comm_reset;
            wake_q  = tx_comm_wake;
            // a short COMINIT while linked tears the link down
            if (linkup) begin
                linked_cycles++;
            end
            if (linked_cycles == LINKED_HOLD) begin
                init_cnt = 3;
            end
            comm_init_detect = (init_cnt > 0);
            comm_wake_detect = (wake_cnt > 0);
            if (init_cnt > 0) begin
                init_cnt--;
            end
            if (wake_cnt > 0) begin
                wake_cnt--;
            end
            if (tx_isk && (tx_dout == `PRIM_ALIGN)) begin
                host_aligned = 1'b1;
            end
        end
        // ALIGN until the host answers, then SYNC or idle dwords
        if (rst || tx_set_elec_idle || !cur_align) begin
            rx_din = '0;
            rx_isk = '0;
            rx_byte_is_aligned = 1'b0;
        end else if (!host_aligned) begin
            rx_din = `PRIM_ALIGN;
            rx_isk = 4'b0001;
            rx_byte_is_aligned = 1'b1;
        end else if (cur_sync) begin
            rx_din = `PRIM_SYNC;
            rx_isk = 4'b0001;
            rx_byte_is_aligned = 1'b1;
        end else begin
            rx_din = '0;
            rx_isk = '0;
            rx_byte_is_aligned = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT never restarted COMRESET",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        platform_ready = 1'b0;
        end_test       = 1'b0;
        load_errors    = 0;
        // fill marks records the file left out
        for (int i = 0; i < NUM_TESTS * FIELDS; i++) begin
            vectors[i] = 32'hFEED_0000 | 32'(i);
        end
        $readmemh("bench/oob_input.txt", vectors);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (vectors[t*FIELDS] != 32'(t + 1)) begin
                $display("record %0d of bench/oob_input.txt is missing or out of order", t + 1);
                load_errors++;
            end
        end
        for (int t = 0; (t < NUM_TESTS) && (load_errors == 0); t++) begin
            cur_test  = int'(vectors[t*FIELDS]);
            cur_init  = vectors[t*FIELDS+1][0];
            cur_wake  = vectors[t*FIELDS+2][0];
            cur_align = vectors[t*FIELDS+3][0];
            cur_sync  = vectors[t*FIELDS+4][0];
            cur_exp   = vectors[t*FIELDS+5][0];
            rst            = 1'b1;
            platform_ready = 1'b0;
            repeat (3) @(negedge clk);
            rst = 1'b0;
            // two idle cycles before the platform is ready
            repeat (2) @(negedge clk);
            platform_ready = 1'b1;
            // test ends when the host starts its retry COMRESET
            rises   = 0;
            burst_q = 1'b0;
            while (rises < 2) begin
                @(negedge clk);
                if (tx_comm_reset && !burst_q) begin
                    rises++;
                end
                burst_q = tx_comm_reset;
            end
            end_test = 1'b1;
            @(negedge clk);
            end_test = 1'b0;
        end
        @(negedge clk);
        $display("tests run %0d of %0d, failed %0d, errors %0d", tests_done, NUM_TESTS,
                 failed_tests, error_count + load_errors);
        if ((error_count == 0) && (load_errors == 0) && (tests_done == NUM_TESTS)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/link_event_if.sv ====
// registered link events passed from the primitive detector to the OOB controller
`timescale 1ns/100ps
`default_nettype none

interface link_event_if;

    // all four are levels, valid every cycle
    logic align_detected;
    logic sync_detected;
    logic init_detected;
    logic wake_detected;

    modport detector (
        output align_detected, sync_detected, init_detected, wake_detected
    );

    modport controller (
        input align_detected, sync_detected, init_detected, wake_detected
    );

endinterface

`default_nettype wire

// ==== hdl/oob_controller.sv ====
// host OOB bring-up FSM, drives COMRESET/COMWAKE strobes, transmit dwords and linkup
`timescale 1ns/100ps
`default_nettype none
`include "sata_oob_config.svh"

module oob_controller
    import sata_prim_pkg::*;
    import oob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  platform_ready,
    link_event_if.controller      events,
    output logic                  linkup,
    output logic                  tx_comm_reset,
    output logic                  tx_comm_wake,
    output logic                  tx_isk,
    output logic                  tx_set_elec_idle,
    output dword_t                tx_dout,
    output oob_state_e            state
);

    // last count value before ALIGN is taken as gone
    localparam gone_count_t GONE_LAST = gone_count_t'(`ALIGN_GONE_COUNT - 1);

    oob_state_e  next_state;
    oob_timer_t  timer;
    oob_timer_t  timer_next;
    gone_count_t gone_count;
    gone_count_t gone_next;
    logic        timeout;

    // value loaded into the timer when a state is entered
    function automatic oob_timer_t entry_load(input oob_state_e s);
        case (s)
            SEND_RESET:   entry_load = oob_timer_t'(`COMRESET_CYCLES);
            WAIT_INIT:    entry_load = oob_timer_t'(`INIT_TIMEOUT);
            WAIT_NO_INIT: entry_load = oob_timer_t'(`INIT_TIMEOUT);
            SEND_WAKE:    entry_load = oob_timer_t'(`COMWAKE_CYCLES);
            WAIT_WAKE:    entry_load = oob_timer_t'(`WAKE_TIMEOUT);
            WAIT_NO_WAKE: entry_load = oob_timer_t'(`WAKE_TIMEOUT);
            WAIT_ALIGN:   entry_load = oob_timer_t'(`ALIGN_TIMEOUT);
            SEND_ALIGN:   entry_load = oob_timer_t'(`ALIGN_TIMEOUT);
            DETECT_SYNC:  entry_load = oob_timer_t'(`SYNC_TIMEOUT);
            // IDLE and READY do not time out
            default:      entry_load = '0;
        endcase
    endfunction

    assign timeout = (timer == '0);

    // next state
    // the event is checked before the timeout in every wait
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (platform_ready) begin
                    next_state = SEND_RESET;
                end
            end
            SEND_RESET: begin
                // burst runs until the timer drains
                if (timeout) begin
                    next_state = WAIT_INIT;
                end
            end
            WAIT_INIT: begin
                if (events.init_detected) begin
                    next_state = WAIT_NO_INIT;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            WAIT_NO_INIT: begin
                // device has finished its COMINIT
                if (!events.init_detected) begin
                    next_state = SEND_WAKE;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            SEND_WAKE: begin
                if (timeout) begin
                    next_state = WAIT_WAKE;
                end
            end
            WAIT_WAKE: begin
                if (events.wake_detected) begin
                    next_state = WAIT_NO_WAKE;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            WAIT_NO_WAKE: begin
                if (!events.wake_detected) begin
                    next_state = WAIT_ALIGN;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            WAIT_ALIGN: begin
                // dialtone goes out until the device locks and sends ALIGN
                if (events.align_detected) begin
                    next_state = SEND_ALIGN;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            SEND_ALIGN: begin
                if (!events.align_detected && (gone_count == GONE_LAST)) begin
                    next_state = DETECT_SYNC;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            DETECT_SYNC: begin
                if (events.sync_detected) begin
                    next_state = READY;
                end else if (timeout) begin
                    next_state = IDLE;
                end
            end
            READY: begin
                // a COMINIT from the device tears the link down
                if (events.init_detected) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // timer reloads on every state change, otherwise drains to zero and holds
    always_comb begin
        if (next_state != state) begin
            timer_next = entry_load(next_state);
        end else if (!timeout) begin
            timer_next = timer - oob_timer_t'(1);
        end else begin
            timer_next = timer;
        end
    end

    // counts only runs of non-ALIGN dwords, any ALIGN restarts it
    always_comb begin
        if ((state != SEND_ALIGN) || events.align_detected) begin
            gone_next = '0;
        end else if (gone_count != GONE_LAST) begin
            gone_next = gone_count + gone_count_t'(1);
        end else begin
            gone_next = gone_count;
        end
    end

    // outputs are registered from next_state so they line up with state
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            timer            <= '0;
            gone_count       <= '0;
            linkup           <= 1'b0;
            tx_comm_reset    <= 1'b0;
            tx_comm_wake     <= 1'b0;
            tx_isk           <= 1'b0;
            tx_set_elec_idle <= 1'b1;
            tx_dout          <= '0;
        end else begin
            state            <= next_state;
            timer            <= timer_next;
            gone_count       <= gone_next;
            linkup           <= (next_state == READY);
            tx_comm_reset    <= (next_state == SEND_RESET);
            tx_comm_wake     <= (next_state == SEND_WAKE);
            // line stays idle through all OOB signalling
            tx_set_elec_idle <= (next_state inside {IDLE, SEND_RESET, WAIT_INIT, WAIT_NO_INIT,
                                                    SEND_WAKE, WAIT_WAKE, WAIT_NO_WAKE});
            case (next_state)
                WAIT_ALIGN: begin
                    tx_dout <= dword_t'(`DIALTONE);
                    tx_isk  <= 1'b0;
                end
                SEND_ALIGN, DETECT_SYNC, READY: begin
                    tx_dout <= dword_t'(`PRIM_ALIGN);
                    tx_isk  <= 1'b1;
                end
                default: begin
                    tx_dout <= '0;
                    tx_isk  <= 1'b0;
                end
            endcase
        end
    end

    // the PHY can only send one OOB burst type at a time
    a_oob_strobes_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        !(tx_comm_reset && tx_comm_wake)
    );

    // linkup register must track the state register
    a_linkup_in_ready : assert property (
        @(posedge clk) disable iff (rst)
        linkup |-> (state == READY)
    );

endmodule

`default_nettype wire

// ==== hdl/oob_pkg.sv ====
// state and counter types of the host OOB bring-up FSM, imported by controller and top level
`default_nettype none

package oob_pkg;

    // host side of the bring-up sequence, in the order it is walked
    typedef enum logic [3:0] {
        IDLE         = 4'h0,
        SEND_RESET   = 4'h1,
        WAIT_INIT    = 4'h2,
        WAIT_NO_INIT = 4'h3,
        SEND_WAKE    = 4'h4,
        WAIT_WAKE    = 4'h5,
        WAIT_NO_WAKE = 4'h6,
        WAIT_ALIGN   = 4'h7,
        SEND_ALIGN   = 4'h8,
        DETECT_SYNC  = 4'h9,
        READY        = 4'hA
    } oob_state_e;

    // loadable down-counter for bursts and waits
    typedef logic [15:0] oob_timer_t;

    // consecutive non-ALIGN cycles seen in SEND_ALIGN
    typedef logic [1:0] gone_count_t;

endpackage

`default_nettype wire

// ==== hdl/prim_detector.sv ====
// decodes ALIGN/SYNC from the receive stream and registers them with the OOB detect levels
`timescale 1ns/100ps
`default_nettype none
`include "sata_oob_config.svh"

module prim_detector
    import sata_prim_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  dword_t                rx_din,
    input  charisk_t              rx_isk,
    input  logic                  rx_byte_is_aligned,
    input  logic                  comm_init_detect,
    input  logic                  comm_wake_detect,
    link_event_if.detector        events
);

    logic align_now;
    logic sync_now;

    // primitives carry their K character in byte 0
    // ALIGN only counts once the deserializer has found the comma
    assign align_now = rx_isk[0] && (rx_din == dword_t'(`PRIM_ALIGN)) && rx_byte_is_aligned;
    assign sync_now  = rx_isk[0] && (rx_din == dword_t'(`PRIM_SYNC));

    // single register stage, every event lags its input by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            events.align_detected <= 1'b0;
            events.sync_detected  <= 1'b0;
            events.init_detected  <= 1'b0;
            events.wake_detected  <= 1'b0;
        end else begin
            events.align_detected <= align_now;
            events.sync_detected  <= sync_now;
            // squelch side levels pass straight through the same stage
            events.init_detected  <= comm_init_detect;
            events.wake_detected  <= comm_wake_detect;
        end
    end

    // one dword can never be both primitives
    a_align_sync_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        !(events.align_detected && events.sync_detected)
    );

endmodule

`default_nettype wire

// ==== hdl/sata_oob_config.svh ====
// primitive values and OOB timeout counts, included by the RTL and the bench for sizing waits
`ifndef SATA_OOB_CONFIG_SVH
`define SATA_OOB_CONFIG_SVH

// ALIGN is K28.5 D10.2 D10.2 D27.3, byte 0 in the low bits
`define PRIM_ALIGN 32'h7B4A4ABC
// SYNC is K28.3 D21.4 D21.5 D21.5
`define PRIM_SYNC 32'hB5B5957C
// D10.2 repeated, the alternating 0/1 dialtone
`define DIALTONE 32'h4A4A4A4A

// burst length counts, the strobe stays high for count+1 cycles
`define COMRESET_CYCLES 16
`define COMWAKE_CYCLES 16

// wait limits in clock cycles
// scaled down for simulation, not the real microsecond values
`define INIT_TIMEOUT 200
`define WAKE_TIMEOUT 200
`define ALIGN_TIMEOUT 400
`define SYNC_TIMEOUT 100

// consecutive cycles without ALIGN before the host looks for SYNC
`define ALIGN_GONE_COUNT 4

`endif

// ==== hdl/sata_oob_top.sv ====
// OOB bring-up stage of the SATA host PHY, joins the primitive detector and the controller
`timescale 1ns/100ps
`default_nettype none

module sata_oob_top
    import sata_prim_pkg::*;
    import oob_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       platform_ready,
    input  dword_t     rx_din,
    input  charisk_t   rx_isk,
    input  logic       rx_byte_is_aligned,
    input  logic       comm_init_detect,
    input  logic       comm_wake_detect,
    output logic       linkup,
    output logic       tx_comm_reset,
    output logic       tx_comm_wake,
    output logic       tx_isk,
    output logic       tx_set_elec_idle,
    output dword_t     tx_dout,
    // debug view of the FSM
    output oob_state_e oob_state
);

    // detector to controller events
    link_event_if events ();

    // rx pins to event is one cycle
    prim_detector u_detector (
        .clk                (clk),
        .rst                (rst),
        .rx_din             (rx_din),
        .rx_isk             (rx_isk),
        .rx_byte_is_aligned (rx_byte_is_aligned),
        .comm_init_detect   (comm_init_detect),
        .comm_wake_detect   (comm_wake_detect),
        .events             (events.detector)
    );

    // event to state change is the second cycle
    oob_controller u_controller (
        .clk              (clk),
        .rst              (rst),
        .platform_ready   (platform_ready),
        .events           (events.controller),
        .linkup           (linkup),
        .tx_comm_reset    (tx_comm_reset),
        .tx_comm_wake     (tx_comm_wake),
        .tx_isk           (tx_isk),
        .tx_set_elec_idle (tx_set_elec_idle),
        .tx_dout          (tx_dout),
        .state            (oob_state)
    );

endmodule

`default_nettype wire

// ==== hdl/sata_prim_pkg.sv ====
// data path types for the receive and transmit dword streams, imported by the PHY blocks
`default_nettype none

package sata_prim_pkg;

    // one 32-bit word as it crosses the parallel PHY interface
    // byte 0 sits in bits 7:0
    typedef logic [31:0] dword_t;

    // per-byte control character flags
    // bit n marks byte n as a K character
    typedef logic [3:0] charisk_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the OOB bring-up testbench with Verilator, runs it and looks for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_sata_oob -f sata_oob.f

sim_output="$(./obj_dir/Vtb_sata_oob)"
echo "$sim_output"

if grep -qx "PASS: all tests" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// ==== sata_oob.f ====
+incdir+hdl
hdl/sata_prim_pkg.sv
hdl/oob_pkg.sv
hdl/link_event_if.sv
hdl/prim_detector.sv
hdl/oob_controller.sv
hdl/sata_oob_top.sv
bench/oob_checker.sv
bench/tb_sata_oob.sv
